/* include/vis_config.svh */
`ifndef VIS_CONFIG_SVH
`define VIS_CONFIG_SVH

// ----------------------------------------------------------------------
// bank geometry
// ----------------------------------------------------------------------
`define VIS_COUNT 24   // blocks per bank, one per correlator
`define VIS_BSIZE 24   // words per block

// datapath
`define VIS_WIDTH 32   // correlator word width

// ----------------------------------------------------------------------
// counter widths
// ----------------------------------------------------------------------
`define VIS_CBITS 5    // block index, covers VIS_COUNT
`define VIS_BBITS 5    // word index, covers VIS_BSIZE
`define VIS_PBITS 2    // pending banks, saturates at 3

`endif

/* verilog/vis_pkg.sv */
`default_nettype none

`include "vis_config.svh"

package vis_pkg;

   // payload and address vectors
   typedef logic [`VIS_WIDTH-1:0]             vis_word_t;
   typedef logic [`VIS_CBITS+`VIS_BBITS-1:0]  vis_addr_t;  // {block, word}

   // counters
   typedef logic [`VIS_CBITS-1:0] blk_cnt_t;
   typedef logic [`VIS_BBITS-1:0] wrd_cnt_t;
   typedef logic [`VIS_PBITS-1:0] bank_cnt_t;  // swaps not yet fetched

   // prefetch sequencing
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,  // buffer empty, waiting for a bank
      ST_FETCH = 2'd1,  // bus cycle open, copying words
      ST_DRAIN = 2'd2,  // last sram write in flight
      ST_FULL  = 2'd3   // bank buffered, waiting for readout
   } prefetch_state_t;

endpackage

`default_nettype wire

/* verilog/bank_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_tracker import vis_pkg::*; (
   input  logic clk_i,
   input  logic rst_i,
   input  logic switch_i,   // correlator bank swapped
   input  logic take_i,     // prefetch started on a bank
   output logic pending_o,  // at least one bank waiting
   output logic overflow_o  // sticky, a swap was dropped
);

   bank_cnt_t count;  // banks swapped but not fetched
   logic      full;

   assign full      = (count == '1);
   assign pending_o = (count != '0);

   // ----------------------------------------------------------------------
   // pending-bank counter, saturating
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count <= '0;
      end else begin
         case ({switch_i, take_i})
            2'b10: if (!full) count <= count + 1'b1;       // new bank, unless full
            2'b01: if (pending_o) count <= count - 1'b1;   // one bank consumed
            default: count <= count;                       // both or neither
         endcase
      end
   end

   // swap into a full counter is lost, flag it for good
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         overflow_o <= 1'b0;
      end else if (switch_i && full && !take_i) begin
         overflow_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verilog/prefetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module prefetch_ctrl import vis_pkg::*; (
   input  logic clk_i,
   input  logic rst_i,
   input  logic pending_i,   // a swapped bank is waiting
   input  logic last_i,      // current address is the final word
   input  logic ack_i,       // bus transfer done
   input  logic streamed_i,  // readout has sent the buffered bank
   output logic start_o,     // begin a bank, also consumes it
   output logic fetch_o,     // bus request level
   output logic ready_o      // bank fully buffered
);

   prefetch_state_t state;
   prefetch_state_t state_nxt;

   // ----------------------------------------------------------------------
   // next-state logic
   // ----------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (pending_i) begin
               state_nxt = ST_FETCH;  // buffer empty and a bank to copy
            end
         end
         ST_FETCH: begin
            if (ack_i && last_i) begin
               state_nxt = ST_DRAIN;  // final word acknowledged
            end
         end
         ST_DRAIN: begin
            state_nxt = ST_FULL;      // one cycle for the last sram write
         end
         ST_FULL: begin
            if (streamed_i) begin
               state_nxt = ST_IDLE;   // buffer free again
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // ----------------------------------------------------------------------
   // outputs
   // ----------------------------------------------------------------------
   // start in the same cycle the tracker sees take
   assign start_o = (state == ST_IDLE) && pending_i;
   assign fetch_o = (state == ST_FETCH);  // cyc and stb follow this

   // pulse on entry to ST_FULL, two cycles after the final ack
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ready_o <= 1'b0;
      end else begin
         ready_o <= (state == ST_DRAIN);
      end
   end

endmodule

`default_nettype wire

/* verilog/prefetch_addr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module prefetch_addr import vis_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      start_i,  // new bank, restart at zero
   input  logic      ack_i,    // word fetched, advance
   output vis_addr_t adr_o,
   output logic      last_o    // final word of the bank
);

   localparam blk_cnt_t BLK_LAST = blk_cnt_t'(`VIS_COUNT - 1);
   localparam wrd_cnt_t WRD_LAST = wrd_cnt_t'(`VIS_BSIZE - 1);

   blk_cnt_t blk;  // correlator block index
   wrd_cnt_t wrd;  // word within block

   // ----------------------------------------------------------------------
   // block and word counters
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i || start_i) begin
         blk <= '0;
         wrd <= '0;
      end else if (ack_i) begin
         if (last_o) begin
            blk <= '0;                // wrap at end of bank
            wrd <= '0;
         end else if (wrd == WRD_LAST) begin
            blk <= blk + 1'b1;        // carry into next block
            wrd <= '0;
         end else begin
            wrd <= wrd + 1'b1;
         end
      end
   end

   assign adr_o  = {blk, wrd};  // block-then-word order
   assign last_o = (blk == BLK_LAST) && (wrd == WRD_LAST);

endmodule

`default_nettype wire

/* verilog/vis_sram_store.sv */
`timescale 1ns/1ps
`default_nettype none

module vis_sram_store import vis_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      start_i,   // clears checksum
   input  logic      fetch_i,   // bus cycle open
   input  logic      ack_i,
   input  vis_addr_t adr_i,     // address of the acked word
   input  vis_word_t dat_i,
   output logic      sram_ce_o,
   output logic      sram_we_o,
   output vis_addr_t sram_ad_o,
   output vis_word_t sram_di_o,
   output vis_word_t checksum_o // xor of the bank so far
);

   logic take_word;

   assign take_word = fetch_i && ack_i;

   // ----------------------------------------------------------------------
   // sram write strobes, one cycle after each ack
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sram_ce_o <= 1'b0;
         sram_we_o <= 1'b0;
      end else begin
         sram_ce_o <= fetch_i;    // enabled through fetch plus drain cycle
         sram_we_o <= take_word;
      end
   end

   // address and data latched at the ack
   always_ff @(posedge clk_i) begin
      if (take_word) begin
         sram_ad_o <= adr_i;
         sram_di_o <= dat_i;
      end
   end

   // running xor, final by the time ready pulses
   always_ff @(posedge clk_i) begin
      if (rst_i || start_i) begin
         checksum_o <= '0;
      end else if (take_word) begin
         checksum_o <= checksum_o ^ dat_i;
      end
   end

endmodule

`default_nettype wire

/* verilog/tart_visibilities.sv */
`timescale 1ns/1ps
`default_nettype none

module tart_visibilities (
   input  logic               clk_i,
   input  logic               rst_i,

   // status from correlators and readout
   input  logic               switch_i,    // bank swap pulse
   input  logic               streamed_i,  // buffered bank sent

   // bus master towards the correlators
   output logic               cyc_o,
   output logic               stb_o,
   output logic               we_o,
   output vis_pkg::vis_addr_t adr_o,
   input  logic               ack_i,
   input  vis_pkg::vis_word_t dat_i,

   // external sram write port
   output logic               sram_ce_o,
   output logic               sram_we_o,
   output vis_pkg::vis_addr_t sram_ad_o,
   output vis_pkg::vis_word_t sram_di_o,

   // status out
   output logic               newblock_o,
   output vis_pkg::vis_word_t checksum_o,
   output logic               overflow_o
);

   logic pending;  // bank waiting in tracker
   logic start;    // bank taken, counters cleared
   logic fetch;    // bus request
   logic last;     // final word addressed

   // ----------------------------------------------------------------------
   // bus mapping, reads only
   // ----------------------------------------------------------------------
   assign cyc_o = fetch;
   assign stb_o = fetch;
   assign we_o  = 1'b0;

   bank_tracker u_tracker (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .switch_i   (switch_i),
      .take_i     (start),
      .pending_o  (pending),
      .overflow_o (overflow_o)
   );

   prefetch_ctrl u_ctrl (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .pending_i  (pending),
      .last_i     (last),
      .ack_i      (ack_i),
      .streamed_i (streamed_i),
      .start_o    (start),
      .fetch_o    (fetch),
      .ready_o    (newblock_o)
   );

   prefetch_addr u_addr (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .start_i (start),
      .ack_i   (ack_i),
      .adr_o   (adr_o),
      .last_o  (last)
   );

   vis_sram_store u_store (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .start_i    (start),
      .fetch_i    (fetch),
      .ack_i      (ack_i),
      .adr_i      (adr_o),
      .dat_i      (dat_i),
      .sram_ce_o  (sram_ce_o),
      .sram_we_o  (sram_we_o),
      .sram_ad_o  (sram_ad_o),
      .sram_di_o  (sram_di_o),
      .checksum_o (checksum_o)
   );

endmodule

`default_nettype wire

/* verif/correlator_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module correlator_model import vis_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      cyc_i,
   input  logic      stb_i,
   input  vis_addr_t adr_i,
   output logic      ack_o,
   output vis_word_t dat_o
);

   integer      seed = 32'h38a9_2095;  // fixed seed, repeatable delays
   integer      delay;
   logic [1:0]  wait_cnt;              // wait cycles left
   logic        busy;                  // request seen, delaying ack
   logic        cyc_q;
   int unsigned bank;                  // banks read so far
   vis_word_t   mix;
   vis_word_t   word;

   // bank times odd constant, xor address, rotate left 7
   assign mix  = vis_word_t'(bank * 32'h9e37_79b1) ^ vis_word_t'(adr_i);
   assign word = {mix[`VIS_WIDTH-8:0], mix[`VIS_WIDTH-1:`VIS_WIDTH-7]};

   always @(posedge clk_i) begin
      if (rst_i) begin
         ack_o    <= 1'b0;
         dat_o    <= '0;
         busy     <= 1'b0;
         wait_cnt <= '0;
         cyc_q    <= 1'b0;
         bank     <= 0;
      end else begin
         cyc_q <= cyc_i;
         if (cyc_q && !cyc_i) bank <= bank + 1;  // bank closed
         ack_o <= 1'b0;                           // ack lasts one cycle
         if (cyc_i && stb_i && !ack_o) begin
            if (!busy) begin
               delay = $random(seed) & 3;         // 0 to 3 wait cycles
               if (delay == 0) begin
                  ack_o <= 1'b1;
                  dat_o <= word;
               end else begin
                  busy     <= 1'b1;
                  wait_cnt <= delay[1:0];
               end
            end else if (wait_cnt == 2'd1) begin
               ack_o <= 1'b1;
               dat_o <= word;
               busy  <= 1'b0;
            end else begin
               wait_cnt <= wait_cnt - 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* verif/tb_tart_visibilities.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module tb_tart_visibilities import vis_pkg::*; ();

   localparam int        WORDS = `VIS_COUNT * `VIS_BSIZE;   // 576 per bank
   localparam int        CYCLE_LIMIT = 20000;  // 4 banks x 576 words x 5 cycles plus margin
   localparam vis_addr_t LAST_ADR = {blk_cnt_t'(`VIS_COUNT-1), wrd_cnt_t'(`VIS_BSIZE-1)};

   logic clk_i, rst_i, switch_i, streamed_i, ack_i;
   logic cyc_o, stb_o, we_o, sram_ce_o, sram_we_o, newblock_o, overflow_o;
   vis_word_t dat_i, sram_di_o, checksum_o, exp_sum;
   vis_addr_t adr_o, sram_ad_o, exp_addr;
   blk_cnt_t  exp_blk;
   wrd_cnt_t  exp_wrd;
   logic [1:0] ack_q;          // final ack delayed by two cycles
   logic      full_wait, ovf_q, switch_seen, ovf_sent;
   int unsigned banks_done, write_cnt, streams_sent;
   int        errors = 0;
   int        cycles = 0;

   tart_visibilities uut (.*);

   correlator_model u_corr (
      .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_o), .stb_i (stb_o),
      .adr_i (adr_o), .ack_o (ack_i), .dat_o (dat_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   function automatic vis_word_t expected_word(input int unsigned bank, input vis_addr_t addr);
      vis_word_t v;
      v = vis_word_t'(bank * 32'h9e37_79b1) ^ vis_word_t'(addr);
      return (v << 7) | (v >> (`VIS_WIDTH - 7));
   endfunction

   task automatic log_error(input string msg);
      errors = errors + 1;
      $display("%s", msg);
   endtask

   // run limit
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // expected sram stream per bank
   // ----------------------------------------------------------------------
   assign exp_addr = {exp_blk, exp_wrd};  // block then word

   always @(posedge clk_i) begin
      if (rst_i) begin
         {exp_blk, exp_wrd, exp_sum, write_cnt, banks_done} <= '0;
         {ack_q, full_wait, ovf_q} <= '0;
      end else begin
         ack_q <= {ack_q[0], stb_o && ack_i && adr_o == LAST_ADR};
         ovf_q <= ovf_sent;
         if (sram_we_o) begin
            exp_sum   <= exp_sum ^ expected_word(banks_done, exp_addr);
            write_cnt <= write_cnt + 1;
            exp_wrd   <= (exp_wrd == `VIS_BSIZE-1) ? '0 : exp_wrd + 1'b1;
            if (exp_wrd == `VIS_BSIZE-1) exp_blk <= exp_blk + 1'b1;
         end
         if (newblock_o) begin
            {exp_blk, exp_wrd, exp_sum, write_cnt} <= '0;
            banks_done <= banks_done + 1;
            full_wait  <= 1'b1;     // buffer held until streamed
         end else if (streamed_i) begin
            full_wait <= 1'b0;
         end
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   a_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
      !switch_seen |-> !cyc_o && !stb_o && !sram_ce_o && !sram_we_o
                       && !newblock_o && !overflow_o)
      else log_error("activity before the first bank swap");
   a_read: assert property (@(posedge clk_i) disable iff (rst_i) !we_o)
      else log_error("bus write issued by a read-only master");
   a_addr: assert property (@(posedge clk_i) disable iff (rst_i)
      sram_we_o |-> sram_ad_o == exp_addr)
      else log_error($sformatf("[FAIL] sram_addr: expected %h, actual %h",
                               $sampled(exp_addr), $sampled(sram_ad_o)));
   a_data: assert property (@(posedge clk_i) disable iff (rst_i)
      sram_we_o |-> sram_di_o == expected_word(banks_done, exp_addr))
      else log_error($sformatf("[FAIL] sram_data: expected %h, actual %h",
                               expected_word($sampled(banks_done), $sampled(exp_addr)),
                               $sampled(sram_di_o)));
   a_ce: assert property (@(posedge clk_i) disable iff (rst_i) sram_we_o |-> sram_ce_o)
      else log_error("sram write without chip enable");
   a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_o && !ack_i |=> stb_o && $stable(adr_o))
      else log_error("request dropped or address moved before ack");
   a_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_o && !(ack_i && adr_o == LAST_ADR) |=> cyc_o)
      else log_error("cyc_o fell before the final ack");
   a_done: assert property (@(posedge clk_i) disable iff (rst_i) newblock_o == ack_q[1])
      else log_error($sformatf("[FAIL] newblock: expected %b, actual %b",
                               $sampled(ack_q[1]), $sampled(newblock_o)));
   a_count: assert property (@(posedge clk_i) disable iff (rst_i)
      newblock_o |-> write_cnt == WORDS)
      else log_error($sformatf("[FAIL] write_count: expected %0d, actual %0d",
                               WORDS, $sampled(write_cnt)));
   a_sum: assert property (@(posedge clk_i) disable iff (rst_i)
      newblock_o |-> checksum_o == exp_sum)
      else log_error($sformatf("[FAIL] checksum: expected %h, actual %h",
                               $sampled(exp_sum), $sampled(checksum_o)));
   a_block: assert property (@(posedge clk_i) disable iff (rst_i)
      full_wait || streams_sent == 4 |-> !cyc_o && !sram_ce_o)
      else log_error("fetch or sram access while buffer full or queue empty");
   a_ovf: assert property (@(posedge clk_i) disable iff (rst_i) overflow_o == ovf_q)
      else log_error($sformatf("[FAIL] overflow: expected %b, actual %b",
                               $sampled(ovf_q), $sampled(overflow_o)));

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   task automatic pulse_switch(input logic lost);
      @(posedge clk_i);
      switch_i    <= 1'b1;
      switch_seen <= 1'b1;
      if (lost) ovf_sent <= 1'b1;  // counter already full
      @(posedge clk_i);
      switch_i <= 1'b0;
   endtask

   task automatic wait_newblock;
      do @(posedge clk_i); while (!newblock_o);
   endtask

   task automatic stream_bank;
      repeat (12) @(posedge clk_i);  // hold the buffer a while
      streamed_i   <= 1'b1;
      streams_sent <= streams_sent + 1;
      @(posedge clk_i);
      streamed_i <= 1'b0;
   endtask

   initial begin
      rst_i = 1'b1;
      switch_i = 1'b0;
      streamed_i = 1'b0;
      switch_seen = 1'b0;
      ovf_sent = 1'b0;
      streams_sent = 0;
      repeat (5) @(posedge clk_i);
      rst_i <= 1'b0;
      repeat (20) @(posedge clk_i);  // idle with nothing allowed to move
      pulse_switch(1'b0);
      wait_newblock();
      // three swaps queue behind the full buffer and the fourth is lost
      repeat (3) pulse_switch(1'b0);
      pulse_switch(1'b1);
      repeat (3) begin
         stream_bank();
         wait_newblock();
      end
      stream_bank();
      repeat (40) @(posedge clk_i);
      assert (banks_done == 4)
      else log_error($sformatf("[FAIL] bank_count: expected 4, actual %0d", banks_done));
      $display("tb_tart_visibilities: %0d errors, %0d banks", errors, banks_done);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
verilog/vis_pkg.sv
verilog/bank_tracker.sv
verilog/prefetch_ctrl.sv
verilog/prefetch_addr.sv
verilog/vis_sram_store.sv
verilog/tart_visibilities.sv
verif/correlator_model.sv
verif/tb_tart_visibilities.sv
